/* Makefile */
# Verilator build of the MSK loopback testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = mskLoopBench
FILELIST  = compile.f
OBJDIR    = obj_dir

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv src/*.svh bench/*.sv bench/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* bench/mskBenchTasks.svh */
`ifndef MSK_BENCH_TASKS_SVH
`define MSK_BENCH_TASKS_SVH

//////////////////////////////////////////////////
// Pseudo-random words
//////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// One LFSR step per bit, LSB filled first
task automatic drawWord(inout logic [31:0] state, output nibble_t word);
	for (int b = 0; b < 4; b++) begin
		state = lfsrStep(state);
		word[b] = state[0];
	end
endtask

//////////////////////////////////////////////////
// Result checks
//////////////////////////////////////////////////

// Received data word
task automatic checkNibble(input string name, input nibble_t actual,
		input nibble_t expected);
	if (actual !== expected) begin
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
		$display("ERRORS FOUND");
		$fatal(1, "data check failed");
	end
endtask

// Single status flag
task automatic checkFlag(input string name, input logic actual,
		input logic expected);
	if (actual !== expected) begin
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
		$display("ERRORS FOUND");
		$fatal(1, "flag check failed");
	end
endtask

`endif

/* bench/mskLoopBench.sv */
`timescale 1ns/1ps

`include "mskSettings.svh"

module mskLoopBench import mskPkg::*; ();

	localparam int clockPeriod     = 8;
	localparam int resetCycles     = 5;
	localparam int fifoDepth       = `MSK_FIFO_DEPTH;
	// Four bits per word, eight samples per bit
	localparam int cyclesPerWord   = 4 * `MSK_SAMPLES_PER_BIT;
	localparam int drainMargin     = 32;
	localparam int watchdogPerWord = 40;
	localparam int watchdogMargin  = 500;
	localparam int numRows         = 8;

	// One test row
	typedef struct packed {
		logic [7:0]	count;
		logic		useRandom;
		nibble_t	pattern;
		logic		readNow;
		logic		resetBefore;
		logic		burst;
	} testRow_t;

	// count, random, pattern, readNow, resetBefore, burst
	localparam testRow_t rowTable [numRows] = '{
		'{8'd1,  1'b0, 4'hA, 1'b1, 1'b0, 1'b0},
		'{8'd16, 1'b1, 4'h0, 1'b1, 1'b0, 1'b1},
		'{8'd2,  1'b0, 4'h0, 1'b1, 1'b0, 1'b0},
		'{8'd2,  1'b0, 4'hF, 1'b1, 1'b0, 1'b0},
		'{8'd17, 1'b1, 4'h0, 1'b0, 1'b0, 1'b1},
		'{8'd20, 1'b1, 4'h0, 1'b0, 1'b0, 1'b0},
		'{8'd1,  1'b0, 4'hA, 1'b1, 1'b1, 1'b0},
		'{8'd8,  1'b1, 4'h0, 1'b1, 1'b0, 1'b0}
	};

	logic			inClock;
	logic			i_reset;
	logic			i_txWrite;
	nibble_t		i_txData;
	logic			o_txFull;
	logic			i_rxRead;
	nibble_t		o_rxData;
	logic			o_rxEmpty;
	logic			o_rxOverflow;

	logic [31:0]	lfsrState;
	logic			overflowExp;
	nibble_t		rowWords [$];
	nibble_t		expectQ [$];

	`include "mskBenchTasks.svh"

	mskLoopTop dut0 (
		.inClock		(inClock		),
		.i_reset		(i_reset		),
		.i_txWrite		(i_txWrite		),
		.i_txData		(i_txData		),
		.o_txFull		(o_txFull		),
		.i_rxRead		(i_rxRead		),
		.o_rxData		(o_rxData		),
		.o_rxEmpty		(o_rxEmpty		),
		.o_rxOverflow	(o_rxOverflow	)
	);

	initial begin
		inClock = 1'b0;
		forever begin
			#(clockPeriod / 2) inClock = ~inClock;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Drive point 1 ns after the rising edge
	task automatic stepCycle();
		@(posedge inClock);
		#1;
	endtask

	task automatic applyReset();
		i_reset = 1'b1;
		repeat (resetCycles) stepCycle();
		checkFlag("o_rxEmpty", o_rxEmpty, 1'b1);
		checkFlag("o_rxOverflow", o_rxOverflow, 1'b0);
		checkFlag("o_txFull", o_txFull, 1'b0);
		i_reset = 1'b0;
		overflowExp = 1'b0;
	endtask

	// Burst writes ignore o_txFull
	task automatic writeWords(input logic burst);
		for (int i = 0; i < rowWords.size(); i++) begin
			if (!burst) begin
				while (o_txFull) begin
					i_txWrite = 1'b0;
					stepCycle();
				end
			end
			i_txWrite = 1'b1;
			i_txData  = rowWords[i];
			stepCycle();
			// Drain is far slower than the write burst
			if (burst && i == fifoDepth - 1) begin
				checkFlag("o_txFull", o_txFull, 1'b1);
			end
		end
		i_txWrite = 1'b0;
	endtask

	task automatic readWords(input logic readNow, input int count);
		nibble_t expected;
		// Deferred reads wait until every word has crossed the link
		if (!readNow) begin
			repeat (count * cyclesPerWord + drainMargin) stepCycle();
		end
		while (expectQ.size() > 0) begin
			expected = expectQ.pop_front();
			while (o_rxEmpty) stepCycle();
			checkNibble("o_rxData", o_rxData, expected);
			i_rxRead = 1'b1;
			stepCycle();
			i_rxRead = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////
	// One table row
	//////////////////////////////////////////////////

	task automatic runRow(input testRow_t row);
		int			accepted;
		int			returned;
		nibble_t	word;
		if (row.resetBefore) begin
			applyReset();
		end
		rowWords.delete();
		expectQ.delete();
		for (int i = 0; i < row.count; i++) begin
			if (row.useRandom) begin
				drawWord(lfsrState, word);
			end else begin
				word = row.pattern;
			end
			rowWords.push_back(word);
		end
		// Tx FIFO drops burst words past its depth
		accepted = (row.burst && row.count > fifoDepth) ? fifoDepth : int'(row.count);
		// Without reads the rx FIFO keeps only its depth
		returned = (!row.readNow && accepted > fifoDepth) ? fifoDepth : accepted;
		for (int i = 0; i < returned; i++) begin
			expectQ.push_back(rowWords[i]);
		end
		if (returned < accepted) begin
			overflowExp = 1'b1;
		end
		fork
			writeWords(row.burst);
			readWords(row.readNow, int'(row.count));
		join
		checkFlag("o_rxEmpty", o_rxEmpty, 1'b1);
		checkFlag("o_rxOverflow", o_rxOverflow, overflowExp);
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		i_reset     = 1'b1;
		i_txWrite   = 1'b0;
		i_txData    = '0;
		i_rxRead    = 1'b0;
		lfsrState   = 32'hc860;
		overflowExp = 1'b0;
		applyReset();
		for (int r = 0; r < numRows; r++) begin
			runRow(rowTable[r]);
		end
		$display("NO ERRORS");
		$finish;
	end

	// Budget of 40 cycles per word plus reset time
	initial begin : watchdog
		int limitCycles;
		limitCycles = watchdogMargin;
		for (int r = 0; r < numRows; r++) begin
			limitCycles += int'(rowTable[r].count) * watchdogPerWord + resetCycles;
		end
		repeat (limitCycles) @(posedge inClock);
		$display("Timeout: the run did not finish within %0d cycles", limitCycles);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

/* compile.f */
+incdir+src
+incdir+bench
src/mskPkg.sv
src/txBitFifo.sv
src/mskModulator.sv
src/phaseDetector.sv
src/symbolRecovery.sv
src/rxNibbleFifo.sv
src/mskLoopTop.sv
bench/mskLoopBench.sv

/* src/mskLoopTop.sv */
`timescale 1ns/1ps

module mskLoopTop import mskPkg::*; (
	input	logic		inClock			,
	input	logic		i_reset			,

	input	logic		i_txWrite		,
	input	nibble_t	i_txData		,
	output	logic		o_txFull		,

	input	logic		i_rxRead		,
	output	nibble_t	o_rxData		,
	output	logic		o_rxEmpty		,
	output	logic		o_rxOverflow
);

	//////////////////////////////////////////////////
	// Stage to stage wires
	//////////////////////////////////////////////////

	// FIFO -> modulator
	logic		txBit;
	logic		txEmpty;
	logic		takeBit;

	// Modulator -> detector
	logic		sampleValid;
	sample_t	sinI;
	sample_t	sinQ;

	// Detector -> recovery
	logic		dirValid;
	logic		dir;

	// Recovery -> receive FIFO
	logic		bitValid;
	logic		rxBit;

	//////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////

	txBitFifo u_txFifo (
		.inClock		(inClock		),
		.i_reset		(i_reset		),
		.i_write		(i_txWrite		),
		.i_data			(i_txData		),
		.i_takeBit		(takeBit		),
		.o_full			(o_txFull		),
		.o_empty		(txEmpty		),
		.o_bit			(txBit			)
	);

	mskModulator u_modulator (
		.inClock		(inClock		),
		.i_reset		(i_reset		),
		.i_bit			(txBit			),
		.i_empty		(txEmpty		),
		.o_takeBit		(takeBit		),
		.o_sampleValid	(sampleValid	),
		.o_sinI			(sinI			),
		.o_sinQ			(sinQ			)
	);

	//////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////

	// Modulator output looped straight into the detector
	phaseDetector u_detector (
		.inClock		(inClock		),
		.i_reset		(i_reset		),
		.i_sampleValid	(sampleValid	),
		.i_sinI			(sinI			),
		.i_sinQ			(sinQ			),
		.o_dirValid		(dirValid		),
		.o_dir			(dir			)
	);

	symbolRecovery u_recovery (
		.inClock		(inClock		),
		.i_reset		(i_reset		),
		.i_dirValid		(dirValid		),
		.i_dir			(dir			),
		.o_bitValid		(bitValid		),
		.o_bit			(rxBit			)
	);

	rxNibbleFifo u_rxFifo (
		.inClock		(inClock		),
		.i_reset		(i_reset		),
		.i_bitValid		(bitValid		),
		.i_bit			(rxBit			),
		.i_read			(i_rxRead		),
		.o_data			(o_rxData		),
		.o_empty		(o_rxEmpty		),
		.o_overflow		(o_rxOverflow	)
	);

endmodule

/* src/mskModulator.sv */
`timescale 1ns/1ps

`include "mskSettings.svh"

module mskModulator import mskPkg::*; (
	input	logic		inClock			,
	input	logic		i_reset			,
	input	logic		i_bit			,
	input	logic		i_empty			,
	output	logic		o_takeBit		,
	output	logic		o_sampleValid	,
	output	sample_t	o_sinI			,
	output	sample_t	o_sinQ
);

	// Cosine of amplitude 7, rounded, one entry per phase step
	localparam sample_t cosTable [`MSK_PHASE_STEPS] = '{
		 4'sd7,  4'sd7,  4'sd6,  4'sd6,  4'sd5,  4'sd4,  4'sd3,  4'sd1,
		 4'sd0, -4'sd1, -4'sd3, -4'sd4, -4'sd5, -4'sd6, -4'sd6, -4'sd7,
		-4'sd7, -4'sd7, -4'sd6, -4'sd6, -4'sd5, -4'sd4, -4'sd3, -4'sd1,
		 4'sd0,  4'sd1,  4'sd3,  4'sd4,  4'sd5,  4'sd6,  4'sd6,  4'sd7
	};

	// Q lags I by a quarter turn, so Q is the sine
	localparam phase_t quarterTurn = phase_t'(`MSK_PHASE_STEPS / 4);

	modState_t	state;
	voteCount_t	sampleCnt;
	logic		curBit;
	logic		lastSample;
	phase_t		phase;
	phase_t		phaseNext;

	//////////////////////////////////////////////////
	// Bit hand-off
	//////////////////////////////////////////////////

	assign lastSample = (sampleCnt == voteCount_t'(`MSK_SAMPLES_PER_BIT - 1));

	// Take a bit when idle, or on the last sample to avoid a gap
	assign o_takeBit = !i_empty &&
		((state == IDLE) || ((state == SENDING) && lastSample));

	// One: quarter turn forward, zero: quarter turn back
	assign phaseNext = curBit ? phase + 1'b1 : phase - 1'b1;

	//////////////////////////////////////////////////
	// FSM and phase accumulator
	//////////////////////////////////////////////////

	always_ff @(posedge inClock) begin
		if (i_reset) begin
			state         <= IDLE;
			sampleCnt     <= '0;
			phase         <= '0;
			o_sampleValid <= 1'b0;
		end else begin
			o_sampleValid <= (state == SENDING);
			case (state)
				IDLE: begin
					if (o_takeBit) begin
						state     <= SENDING;
						sampleCnt <= '0;
					end
				end
				SENDING: begin
					// Phase carries over between bits and through idle
					phase <= phaseNext;
					if (lastSample) begin
						sampleCnt <= '0;
						if (!o_takeBit) begin
							state <= IDLE;
						end
					end else begin
						sampleCnt <= sampleCnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Bit latch and sample lookup
	always_ff @(posedge inClock) begin
		if (o_takeBit) begin
			curBit <= i_bit;
		end
		if (state == SENDING) begin
			o_sinI <= cosTable[phaseNext];
			o_sinQ <= cosTable[phaseNext - quarterTurn];
		end
	end

endmodule

/* src/mskPkg.sv */
package mskPkg;

	//////////////////////////////////////////////////
	// Data words and samples
	//////////////////////////////////////////////////

	// User word, four bits, LSB sent first
	typedef logic [3:0] nibble_t;

	// Signed I or Q sample
	typedef logic signed [3:0] sample_t;

	// Index into the cosine table
	typedef logic [4:0] phase_t;

	// FIFO pointer, MSB is the wrap bit
	typedef logic [4:0] fifoPtr_t;

	// Sample and vote counter, counts up to 8
	typedef logic [3:0] voteCount_t;

	// Cross product of two sample pairs
	typedef logic signed [8:0] crossProduct_t;

	// Modulator FSM
	typedef enum logic {IDLE, SENDING} modState_t;

endpackage

/* src/mskSettings.svh */
`ifndef MSK_SETTINGS_SVH
`define MSK_SETTINGS_SVH

// Samples produced for every transmitted bit
`define MSK_SAMPLES_PER_BIT 8

// Table entries around one full carrier turn
// One bit moves the phase a quarter turn
`define MSK_PHASE_STEPS 32

// Words held by each FIFO
`define MSK_FIFO_DEPTH 16

// Peak table amplitude
`define MSK_SAMPLE_MAX 7

`endif

/* src/phaseDetector.sv */
`timescale 1ns/1ps

`include "mskSettings.svh"

module phaseDetector import mskPkg::*; (
	input	logic		inClock			,
	input	logic		i_reset			,
	input	logic		i_sampleValid	,
	input	sample_t	i_sinI			,
	input	sample_t	i_sinQ			,
	output	logic		o_dirValid		,
	output	logic		o_dir
);

	sample_t		prevI;
	sample_t		prevQ;
	crossProduct_t	crossProd;

	//////////////////////////////////////////////////
	// Rotation from previous to current sample
	//////////////////////////////////////////////////

	// Sign of prev x curr gives the direction
	// Operands widened with their sign
	assign crossProd = crossProduct_t'(prevI) * crossProduct_t'(i_sinQ) -
		crossProduct_t'(prevQ) * crossProduct_t'(i_sinI);

	always_ff @(posedge inClock) begin
		if (i_reset) begin
			// Matches modulator phase 0 after reset
			prevI      <= sample_t'(`MSK_SAMPLE_MAX);
			prevQ      <= '0;
			o_dirValid <= 1'b0;
		end else begin
			o_dirValid <= i_sampleValid;
			// Last pair held across gaps
			if (i_sampleValid) begin
				prevI <= i_sinI;
				prevQ <= i_sinQ;
			end
		end
	end

	// Positive cross product means counter-clockwise
	always_ff @(posedge inClock) begin
		if (i_sampleValid) begin
			o_dir <= (crossProd > 0);
		end
	end

endmodule

/* src/rxNibbleFifo.sv */
`timescale 1ns/1ps

`include "mskSettings.svh"

module rxNibbleFifo import mskPkg::*; (
	input	logic		inClock		,
	input	logic		i_reset		,
	input	logic		i_bitValid	,
	input	logic		i_bit		,
	input	logic		i_read		,
	output	nibble_t	o_data		,
	output	logic		o_empty		,
	output	logic		o_overflow
);

	localparam int addrBits = $clog2(`MSK_FIFO_DEPTH);

	nibble_t	mem [`MSK_FIFO_DEPTH];
	nibble_t	shiftReg;
	nibble_t	packedWord;
	logic [1:0]	bitCnt;
	logic		wordDone;
	logic		full;
	logic		doWrite;
	logic		doRead;
	fifoPtr_t	wrPtr;
	fifoPtr_t	rdPtr;

	//////////////////////////////////////////////////
	// Bit packer
	//////////////////////////////////////////////////

	// LSB first, new bit enters at the top
	assign packedWord = {i_bit, shiftReg[3:1]};
	assign wordDone   = i_bitValid && (bitCnt == 2'd3);

	always_ff @(posedge inClock) begin
		if (i_bitValid) begin
			shiftReg <= packedWord;
		end
	end

	//////////////////////////////////////////////////
	// Word buffer
	//////////////////////////////////////////////////

	assign full    = (wrPtr[addrBits] != rdPtr[addrBits]) &&
		(wrPtr[addrBits-1:0] == rdPtr[addrBits-1:0]);
	assign o_empty = (wrPtr == rdPtr);
	assign doWrite = wordDone && !full;
	// Reads on empty are ignored
	assign doRead  = i_read && !o_empty;

	// Head word, zero while empty
	assign o_data = o_empty ? '0 : mem[rdPtr[addrBits-1:0]];

	always_ff @(posedge inClock) begin
		if (doWrite) begin
			mem[wrPtr[addrBits-1:0]] <= packedWord;
		end
	end

	always_ff @(posedge inClock) begin
		if (i_reset) begin
			bitCnt     <= '0;
			wrPtr      <= '0;
			rdPtr      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (i_bitValid) begin
				bitCnt <= bitCnt + 1'b1;
			end
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Sticky until reset
			if (wordDone && full) begin
				o_overflow <= 1'b1;
			end
		end
	end

endmodule

/* src/symbolRecovery.sv */
`timescale 1ns/1ps

`include "mskSettings.svh"

module symbolRecovery import mskPkg::*; (
	input	logic	inClock		,
	input	logic	i_reset		,
	input	logic	i_dirValid	,
	input	logic	i_dir		,
	output	logic	o_bitValid	,
	output	logic	o_bit
);

	logic		prevValid;
	logic		windowEnd;
	voteCount_t	sampleCnt;
	voteCount_t	voteCnt;
	voteCount_t	baseCnt;
	voteCount_t	baseVotes;
	voteCount_t	nextCnt;
	voteCount_t	nextVotes;

	//////////////////////////////////////////////////
	// Window counting
	//////////////////////////////////////////////////

	// A gap before this direction starts a fresh window
	always_comb begin
		baseCnt   = prevValid ? sampleCnt : '0;
		baseVotes = prevValid ? voteCnt : '0;
		nextCnt   = baseCnt + 1'b1;
		nextVotes = baseVotes + voteCount_t'(i_dir);
	end

	assign windowEnd = i_dirValid &&
		(nextCnt == voteCount_t'(`MSK_SAMPLES_PER_BIT));

	always_ff @(posedge inClock) begin
		if (i_reset) begin
			prevValid  <= 1'b0;
			sampleCnt  <= '0;
			voteCnt    <= '0;
			o_bitValid <= 1'b0;
		end else begin
			prevValid  <= i_dirValid;
			o_bitValid <= windowEnd;
			if (windowEnd) begin
				sampleCnt <= '0;
				voteCnt   <= '0;
			end else if (i_dirValid) begin
				sampleCnt <= nextCnt;
				voteCnt   <= nextVotes;
			end
		end
	end

	// Majority, more than half counter-clockwise -> one
	always_ff @(posedge inClock) begin
		if (windowEnd) begin
			o_bit <= (nextVotes > voteCount_t'(`MSK_SAMPLES_PER_BIT / 2));
		end
	end

endmodule

/* src/txBitFifo.sv */
`timescale 1ns/1ps

`include "mskSettings.svh"

module txBitFifo import mskPkg::*; (
	input	logic		inClock		,
	input	logic		i_reset		,
	input	logic		i_write		,
	input	nibble_t	i_data		,
	input	logic		i_takeBit	,
	output	logic		o_full		,
	output	logic		o_empty		,
	output	logic		o_bit
);

	// Address bits below the wrap bit
	localparam int addrBits = $clog2(`MSK_FIFO_DEPTH);

	nibble_t	mem [`MSK_FIFO_DEPTH];
	fifoPtr_t	wrPtr;
	fifoPtr_t	rdPtr;
	logic [1:0]	bitIdx;
	logic		doWrite;
	logic		doTake;

	//////////////////////////////////////////////////
	// Flags
	//////////////////////////////////////////////////

	// Same address, different lap -> full
	assign o_full  = (wrPtr[addrBits] != rdPtr[addrBits]) &&
		(wrPtr[addrBits-1:0] == rdPtr[addrBits-1:0]);
	assign o_empty = (wrPtr == rdPtr);

	// Writes into a full buffer are dropped
	assign doWrite = i_write && !o_full;
	assign doTake  = i_takeBit && !o_empty;

	// Current bit of the head word
	assign o_bit = mem[rdPtr[addrBits-1:0]][bitIdx];

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge inClock) begin
		if (doWrite) begin
			mem[wrPtr[addrBits-1:0]] <= i_data;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and bit index
	//////////////////////////////////////////////////

	always_ff @(posedge inClock) begin
		if (i_reset) begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			bitIdx <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doTake) begin
				bitIdx <= bitIdx + 1'b1;
				// Word done after bit 3, move to next word
				if (bitIdx == 2'd3) begin
					rdPtr <= rdPtr + 1'b1;
				end
			end
		end
	end

endmodule
